// File: include/gf_settings.svh
`ifndef GF_SETTINGS_SVH
`define GF_SETTINGS_SVH

// Field degree, bits per element
`define GF_M 6

// Low GF_M bits of the primitive polynomial x^6 + x + 1
`define GF_POLY 6'b000011

// Result register file
`define RES_DEPTH 8
`define RES_AW 3

`endif

// File: source/gf_pkg.sv
`default_nettype none

`include "gf_settings.svh"

package gf_pkg;

	// One field element in standard basis
	typedef logic [`GF_M-1:0] elem_t;

	// Result memory address
	typedef logic [`RES_AW-1:0] addr_t;

	// Shared by both engines
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_WRITE
	} engine_state_t;

endpackage

`default_nettype wire

// File: source/gf_mult_parallel.sv
`timescale 1ns/100ps
`default_nettype none

`include "gf_settings.svh"

module gf_mult_parallel import gf_pkg::*; (
	input elem_t a,
	input elem_t b,
	output elem_t p
);
	logic [2*`GF_M-2:0] prod;
	logic [2*`GF_M-2:0] rem;

	// Carry-less polynomial product
	always_comb begin
		prod = '0;
		for (int i = 0; i < `GF_M; i++) begin
			if (b[i])
				prod = prod ^ ({{(`GF_M-1){1'b0}}, a} << i);
		end
	end

	// Fold the high terms back, top degree first
	always_comb begin
		rem = prod;
		for (int i = 2*`GF_M-2; i >= `GF_M; i--) begin
			if (rem[i])
				rem[i-:`GF_M+1] = rem[i-:`GF_M+1] ^ {1'b1, `GF_POLY};
		end
	end

	assign p = rem[`GF_M-1:0];
endmodule

`default_nettype wire

// File: source/gf_mult_serial.sv
`timescale 1ns/100ps
`default_nettype none

`include "gf_settings.svh"

module gf_mult_serial import gf_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input elem_t a,
	input elem_t b,
	input addr_t dest,
	output logic busy,
	output logic done,
	output logic wr_req,
	output elem_t wr_data,
	output addr_t wr_addr,
	input logic grant
);
	localparam int CW = $clog2(`GF_M);
	localparam logic [CW-1:0] LAST = CW'(`GF_M - 1);

	engine_state_t state;
	logic [CW-1:0] bit_cnt;
	elem_t a_reg;
	elem_t b_reg;
	elem_t acc;
	addr_t dest_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: if (start) begin
					state <= ST_RUN;
					bit_cnt <= '0;
				end
				ST_RUN: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == LAST)
						state <= ST_WRITE;
				end
				ST_WRITE: if (grant)
					state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Datapath, MSB of a first
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start) begin
			a_reg <= a;
			b_reg <= b;
			dest_reg <= dest;
			acc <= '0;
		end else if (state == ST_RUN) begin
			a_reg <= a_reg << 1;
			acc <= {acc[`GF_M-2:0], 1'b0} ^ ({`GF_M{acc[`GF_M-1]}} & `GF_POLY)
				^ ({`GF_M{a_reg[`GF_M-1]}} & b_reg);
		end
	end

	assign busy = state != ST_IDLE;
	assign wr_req = state == ST_WRITE;
	assign done = wr_req & grant;
	assign wr_data = acc;
	assign wr_addr = dest_reg;
endmodule

`default_nettype wire

// File: source/gf_divider.sv
`timescale 1ns/100ps
`default_nettype none

`include "gf_settings.svh"

// Quotient = numer * denom^(2^M - 2), the product of denom^(2^k) for k = 1 .. M-1
module gf_divider import gf_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input elem_t numer,
	input elem_t denom,
	input addr_t dest,
	output logic busy,
	output logic done,
	output logic wr_req,
	output elem_t wr_data,
	output addr_t wr_addr,
	input logic grant
);
	localparam int CW = $clog2(`GF_M);
	localparam logic [CW-1:0] LAST = CW'(`GF_M - 1);

	engine_state_t state;
	logic [CW-1:0] cyc_cnt;
	logic last_cyc;
	elem_t sq_reg;
	elem_t acc;
	elem_t numer_reg;
	addr_t dest_reg;
	elem_t sq_in;
	elem_t sq_out;
	elem_t mul_b;
	elem_t mul_out;

	assign last_cyc = cyc_cnt == LAST;

	// Idle squares the incoming denominator, run squares the held term
	assign sq_in = (state == ST_IDLE) ? denom : sq_reg;

	gf_mult_parallel sq_mult_i (
		.a(sq_in),
		.b(sq_in),
		.p(sq_out)
	);

	// Last run cycle reuses the accumulator multiplier for the numerator
	assign mul_b = last_cyc ? numer_reg : sq_reg;

	gf_mult_parallel acc_mult_i (
		.a(acc),
		.b(mul_b),
		.p(mul_out)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			cyc_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: if (start) begin
					state <= ST_RUN;
					cyc_cnt <= '0;
				end
				ST_RUN: begin
					cyc_cnt <= cyc_cnt + 1'b1;
					if (last_cyc)
						state <= ST_WRITE;
				end
				ST_WRITE: if (grant)
					state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start) begin
			sq_reg <= sq_out;
			acc <= `GF_M'(1);
			numer_reg <= numer;
			dest_reg <= dest;
		end else if (state == ST_RUN) begin
			sq_reg <= sq_out;
			acc <= mul_out;
		end
	end

	assign busy = state != ST_IDLE;
	assign wr_req = state == ST_WRITE;
	assign done = wr_req & grant;
	assign wr_data = acc;
	assign wr_addr = dest_reg;
endmodule

`default_nettype wire

// File: source/result_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "gf_settings.svh"

module result_arbiter import gf_pkg::*; (
	input logic clk,
	input logic reset,
	input logic req_mul,
	input addr_t addr_mul,
	input elem_t data_mul,
	input logic req_div,
	input addr_t addr_div,
	input elem_t data_div,
	output logic grant_mul,
	output logic grant_div,
	output logic we,
	output addr_t waddr,
	output elem_t wdata
);
	// High when the divider wins the next tie
	logic prio_div;
	logic contested;

	assign contested = req_mul & req_div;

	assign grant_mul = req_mul & (~req_div | ~prio_div);
	assign grant_div = req_div & (~req_mul | prio_div);

	// Flip only when both asked, so the loser goes first next time
	always_ff @(posedge clk) begin
		if (reset)
			prio_div <= 1'b0;
		else if (contested)
			prio_div <= ~prio_div;
	end

	assign we = grant_mul | grant_div;
	assign waddr = grant_div ? addr_div : addr_mul;
	assign wdata = grant_div ? data_div : data_mul;
endmodule

`default_nettype wire

// File: source/result_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "gf_settings.svh"

module result_ram import gf_pkg::*; (
	input logic clk,
	input logic we,
	input addr_t waddr,
	input elem_t wdata,
	input addr_t rd_addr,
	output elem_t rd_data
);
	elem_t mem [`RES_DEPTH];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// One cycle read latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end
endmodule

`default_nettype wire

// File: source/gf_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "gf_settings.svh"

module gf_unit_top import gf_pkg::*; (
	input logic clk,
	input logic reset,
	input logic mul_start,
	input elem_t mul_a,
	input elem_t mul_b,
	input addr_t mul_dest,
	output logic mul_busy,
	output logic mul_done,
	input logic div_start,
	input elem_t div_numer,
	input elem_t div_denom,
	input addr_t div_dest,
	output logic div_busy,
	output logic div_done,
	input addr_t rd_addr,
	output elem_t rd_data
);
	logic mul_req;
	elem_t mul_data;
	addr_t mul_addr;
	logic mul_grant;
	logic div_req;
	elem_t div_data;
	addr_t div_addr;
	logic div_grant;
	logic we;
	addr_t waddr;
	elem_t wdata;

	gf_mult_serial mult_i (
		.clk(clk),
		.reset(reset),
		.start(mul_start),
		.a(mul_a),
		.b(mul_b),
		.dest(mul_dest),
		.busy(mul_busy),
		.done(mul_done),
		.wr_req(mul_req),
		.wr_data(mul_data),
		.wr_addr(mul_addr),
		.grant(mul_grant)
	);

	gf_divider div_i (
		.clk(clk),
		.reset(reset),
		.start(div_start),
		.numer(div_numer),
		.denom(div_denom),
		.dest(div_dest),
		.busy(div_busy),
		.done(div_done),
		.wr_req(div_req),
		.wr_data(div_data),
		.wr_addr(div_addr),
		.grant(div_grant)
	);

	// One shared write port for both engines
	result_arbiter arb_i (
		.clk(clk),
		.reset(reset),
		.req_mul(mul_req),
		.addr_mul(mul_addr),
		.data_mul(mul_data),
		.req_div(div_req),
		.addr_div(div_addr),
		.data_div(div_data),
		.grant_mul(mul_grant),
		.grant_div(div_grant),
		.we(we),
		.waddr(waddr),
		.wdata(wdata)
	);

	result_ram ram_i (
		.clk(clk),
		.we(we),
		.waddr(waddr),
		.wdata(wdata),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);
endmodule

`default_nettype wire

// File: test/gf_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "gf_settings.svh"

module gf_unit_tb import gf_pkg::*; ();
	localparam int RESET_CYCLES = 16;
	localparam int N_OPS = 204;
	localparam int CYCLE_LIMIT = N_OPS * 4 * (`GF_M + 4) + RESET_CYCLES;

	logic clk = 1'b0;
	logic reset;
	logic mul_start, div_start;
	elem_t mul_a, mul_b, div_numer, div_denom;
	addr_t mul_dest, div_dest, rd_addr;
	logic mul_busy, mul_done, div_busy, div_done;
	elem_t rd_data;

	logic [15:0] lfsr_state;
	int error_cnt = 0;
	int cycle_cnt = 0;
	int mul_done_cnt = 0;
	int div_done_cnt = 0;
	int mul_done_cyc, div_done_cyc;
	elem_t exp_mem [`RES_DEPTH];
	elem_t pend_mul_val, pend_div_val;
	addr_t pend_mul_dest, pend_div_dest;
	logic mul_inflight = 1'b0;
	logic div_inflight = 1'b0;

	gf_unit_top dut_i (
		.clk(clk), .reset(reset),
		.mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b), .mul_dest(mul_dest),
		.mul_busy(mul_busy), .mul_done(mul_done),
		.div_start(div_start), .div_numer(div_numer), .div_denom(div_denom),
		.div_dest(div_dest), .div_busy(div_busy), .div_done(div_done),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

	always #20 clk = ~clk;

	// Watchdog
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles, %0d errors so far",
				CYCLE_LIMIT, error_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Commit the pending model result when the engine writes
	always @(negedge clk) begin
		if (!reset && mul_done) begin
			exp_mem[pend_mul_dest] = pend_mul_val;
			mul_inflight = 1'b0;
			mul_done_cnt++;
			mul_done_cyc = cycle_cnt;
		end
		if (!reset && div_done) begin
			exp_mem[pend_div_dest] = pend_div_val;
			div_inflight = 1'b0;
			div_done_cnt++;
			div_done_cyc = cycle_cnt;
		end
	end

	// 16-bit Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// LSB-first shift and reduce
	function automatic elem_t gf_mul_model(input elem_t x, input elem_t y);
		elem_t r;
		elem_t t;
		logic carry;
		r = '0;
		t = x;
		for (int i = 0; i < `GF_M; i++) begin
			if (y[i])
				r = r ^ t;
			carry = t[`GF_M-1];
			t = t << 1;
			if (carry)
				t = t ^ `GF_POLY;
		end
		return r;
	endfunction

	// Inverse by exhaustive search
	// A zero divisor has no inverse and gives zero
	function automatic elem_t gf_div_model(input elem_t n, input elem_t d);
		elem_t inv;
		inv = '0;
		for (int x = 1; x < (1 << `GF_M); x++) begin
			if (gf_mul_model(d, elem_t'(x)) == elem_t'(1))
				inv = elem_t'(x);
		end
		return gf_mul_model(n, inv);
	endfunction

	task automatic check_elem(input elem_t got, input elem_t exp, input string what);
		if (got !== exp) begin
			error_cnt++;
			$display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			error_cnt++;
			$display("mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	// The model takes a new command only while it holds none in flight
	task automatic start_mul(input elem_t a, input elem_t b, input addr_t dest);
		mul_start = 1'b1;
		mul_a = a;
		mul_b = b;
		mul_dest = dest;
		if (!mul_inflight) begin
			pend_mul_val = gf_mul_model(a, b);
			pend_mul_dest = dest;
			mul_inflight = 1'b1;
		end
		step_cycle();
		mul_start = 1'b0;
	endtask

	task automatic start_div(input elem_t n, input elem_t d, input addr_t dest);
		div_start = 1'b1;
		div_numer = n;
		div_denom = d;
		div_dest = dest;
		if (!div_inflight) begin
			pend_div_val = gf_div_model(n, d);
			pend_div_dest = dest;
			div_inflight = 1'b1;
		end
		step_cycle();
		div_start = 1'b0;
	endtask

	task automatic wait_results(input int mul_target, input int div_target);
		while (mul_done_cnt < mul_target || div_done_cnt < div_target)
			step_cycle();
	endtask

	task automatic read_check(input addr_t addr, input string what);
		rd_addr = addr;
		step_cycle();
		check_elem(rd_data, exp_mem[addr], what);
	endtask

	initial begin
		logic [31:0] r;
		elem_t a;
		elem_t b;
		addr_t dest;
		int m_target;
		mul_start = 1'b0;
		div_start = 1'b0;
		mul_a = '0;
		mul_b = '0;
		mul_dest = '0;
		div_numer = '0;
		div_denom = '0;
		div_dest = '0;
		rd_addr = '0;
		reset = 1'b1;
		lfsr_state = 16'd76;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;

		check_flag(mul_busy, 1'b0, "mul_busy after reset");
		check_flag(div_busy, 1'b0, "div_busy after reset");
		check_flag(mul_done, 1'b0, "mul_done after reset");
		check_flag(div_done, 1'b0, "div_done after reset");

		for (int n = 0; n < 100; n++) begin
			get_bits(`GF_M, r);
			a = r[`GF_M-1:0];
			get_bits(`GF_M, r);
			b = r[`GF_M-1:0];
			get_bits(`RES_AW, r);
			dest = r[`RES_AW-1:0];
			start_mul(a, b, dest);
			wait_results(mul_done_cnt + 1, 0);
			read_check(dest, "multiply readback");
		end

		// About one in eight divisors forced to zero
		for (int n = 0; n < 100; n++) begin
			get_bits(`GF_M, r);
			a = r[`GF_M-1:0];
			get_bits(3, r);
			b = '0;
			if (r[2:0] != 3'd0) begin
				get_bits(`GF_M, r);
				b = r[`GF_M-1:0];
			end
			get_bits(`RES_AW, r);
			dest = r[`RES_AW-1:0];
			start_div(a, b, dest);
			wait_results(0, div_done_cnt + 1);
			read_check(dest, "divide readback");
		end

		// Same-cycle starts collide at the write port
		get_bits(`RES_AW, r);
		dest = r[`RES_AW-1:0];
		mul_start = 1'b1;
		mul_a = 6'h2b;
		mul_b = 6'h19;
		mul_dest = dest;
		pend_mul_val = gf_mul_model(6'h2b, 6'h19);
		pend_mul_dest = dest;
		mul_inflight = 1'b1;
		start_div(6'h37, 6'h0e, dest ^ 1'b1);
		mul_start = 1'b0;
		check_flag(div_busy, 1'b1, "div_busy during run");
		wait_results(mul_done_cnt + 1, div_done_cnt + 1);
		check_flag(mul_done_cyc == div_done_cyc, 1'b0, "done pulses in one cycle");
		read_check(dest, "contested multiply readback");
		read_check(dest ^ 1'b1, "contested divide readback");

		// Start while busy must not reach its destination
		start_mul(6'h11, 6'h22, addr_t'(5));
		wait_results(mul_done_cnt + 1, 0);
		m_target = mul_done_cnt + 1;
		start_mul(6'h3c, 6'h07, addr_t'(2));
		start_mul(6'h15, 6'h2a, addr_t'(5));
		check_flag(mul_busy, 1'b1, "mul_busy during run");
		wait_results(m_target, 0);
		repeat (2 * (`GF_M + 4)) step_cycle();
		check_flag(mul_done_cnt == m_target, 1'b1, "single done after ignored start");
		read_check(addr_t'(2), "accepted multiply readback");
		read_check(addr_t'(5), "ignored destination readback");

		$display("run finished: %0d errors in %0d cycles", error_cnt, cycle_cnt);
		if (error_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// File: build.f
+incdir+include
source/gf_pkg.sv
source/gf_mult_parallel.sv
source/gf_mult_serial.sv
source/gf_divider.sv
source/result_arbiter.sv
source/result_ram.sv
source/gf_unit_top.sv
test/gf_unit_tb.sv
